//--- dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
	input  logic                   clk_i,
	input  logic                   rst_i,

	// processor side
	input  dcache_pkg::cpu_req_t   cpu_req_i,
	output dcache_pkg::word_t      rdata_o,
	output logic                   stall_o,

	// memory side
	output dcache_pkg::mem_req_t   mem_req_o,
	input  logic                   mem_ack_i,
	input  dcache_pkg::line_t      mem_rdata_i,

	// tag and data arrays
	output dcache_pkg::index_t     sram_index_o,
	output logic                   tag_we_o,
	output dcache_pkg::tag_entry_t tag_wdata_o,
	input  dcache_pkg::tag_entry_t tag_rdata_i,
	output logic                   data_we_o,
	output dcache_pkg::line_t      data_wdata_o,
	input  dcache_pkg::line_t      data_rdata_i
);

	import dcache_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	// request fields
	logic        req;
	tag_t        req_tag;
	index_t      req_index;
	word_sel_t   req_word;

	// lookup results
	logic        hit;
	logic        victim_dirty;
	logic        write_hit;
	logic        refill_done;

	// line addresses toward memory
	addr_t       req_line_addr;
	addr_t       victim_line_addr;

	// stored line with the write word merged in
	line_t       merged_line;

	assign req = cpu_req_i.rd | cpu_req_i.wr;

	// address split
	assign req_tag   = cpu_req_i.addr[`ADDR_BITS-1 -: `TAG_BITS];
	assign req_index = cpu_req_i.addr[`OFFSET_BITS +: `INDEX_BITS];
	assign req_word  = cpu_req_i.addr[`BYTE_SEL_BITS +: `WORD_SEL_BITS];

	// an invalid entry never hits
	assign hit = tag_rdata_i.valid && (tag_rdata_i.tag == req_tag);

	// victim needs writing back only if it holds modified data
	assign victim_dirty = tag_rdata_i.valid && tag_rdata_i.dirty;

	// write hits only commit from IDLE where the request completes
	assign write_hit = (state_q == IDLE) && cpu_req_i.wr && hit;

	// refill line arrives with the acknowledge
	assign refill_done = (state_q == REFILL) && mem_ack_i;

	// stall until a lookup in IDLE hits
	// FILL still stalls although the new tag is already in place
	assign stall_o = req && !((state_q == IDLE) && hit);

	// word select for reads
	assign rdata_o = data_rdata_i[req_word*`WORD_BITS +: `WORD_BITS];

	// merge the write word into the stored line
	always_comb begin
		merged_line = data_rdata_i;
		merged_line[req_word*`WORD_BITS +: `WORD_BITS] = cpu_req_i.wdata;
	end

	// line aligned addresses
	assign req_line_addr    = {req_tag, req_index, {`OFFSET_BITS{1'b0}}};
	assign victim_line_addr = {tag_rdata_i.tag, req_index, {`OFFSET_BITS{1'b0}}};

	// next state
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (req && !hit) begin
					state_d = MISS;
				end
			end
			MISS: begin
				// victim decides between write-back and a plain refill
				if (victim_dirty) begin
					state_d = WRITEBACK;
				end else begin
					state_d = REFILL;
				end
			end
			WRITEBACK: begin
				if (mem_ack_i) begin
					state_d = REFILL;
				end
			end
			REFILL: begin
				if (mem_ack_i) begin
					state_d = FILL;
				end
			end
			FILL: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_i) begin
		if (!rst_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// memory request decoded from the state
	// fields stay steady while waiting for the acknowledge
	always_comb begin
		mem_req_o.enable = (state_q == WRITEBACK) || (state_q == REFILL);
		mem_req_o.write  = (state_q == WRITEBACK);
		if (state_q == WRITEBACK) begin
			mem_req_o.addr = victim_line_addr;
		end else begin
			mem_req_o.addr = req_line_addr;
		end
		// old line is still in the array during write-back
		mem_req_o.data = data_rdata_i;
	end

	// both arrays follow the request index
	assign sram_index_o = req_index;

	// arrays written on a write hit or a completed refill
	assign tag_we_o  = write_hit || refill_done;
	assign data_we_o = write_hit || refill_done;

	// refill leaves the line clean and a write hit marks it dirty
	always_comb begin
		tag_wdata_o.valid = 1'b1;
		tag_wdata_o.dirty = write_hit;
		tag_wdata_o.tag   = req_tag;
	end

	// fetched line on refill and merged line on a write hit
	always_comb begin
		if (refill_done) begin
			data_wdata_o = mem_rdata_i;
		end else begin
			data_wdata_o = merged_line;
		end
	end

endmodule

//--- dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DCACHE_LINES    32
`define LINE_BITS       256
`define WORD_BITS       32

// processor byte address
`define ADDR_BITS       32

// address split into tag | index | offset
`define INDEX_BITS      5
`define OFFSET_BITS     5
`define TAG_BITS        (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)

// word select sits above byte select in the offset
`define BYTE_SEL_BITS   2
`define WORD_SEL_BITS   (`OFFSET_BITS - `BYTE_SEL_BITS)

// tag entry is valid, dirty and tag
`define TAG_ENTRY_BITS  (`TAG_BITS + 2)

`endif

//--- dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

	// widths with a meaning
	typedef logic [`ADDR_BITS-1:0]     addr_t;
	typedef logic [`WORD_BITS-1:0]     word_t;
	typedef logic [`LINE_BITS-1:0]     line_t;
	typedef logic [`TAG_BITS-1:0]      tag_t;
	typedef logic [`INDEX_BITS-1:0]    index_t;
	typedef logic [`WORD_SEL_BITS-1:0] word_sel_t;

	// one entry of the tag array
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	// load/store request from the processor
	typedef struct packed {
		logic  rd;
		logic  wr;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// line request toward the data memory
	// addr is always line aligned
	typedef struct packed {
		logic  enable;
		logic  write;
		addr_t addr;
		line_t data;
	} mem_req_t;

	// miss handling FSM
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		MISS      = 3'd1,
		WRITEBACK = 3'd2,
		REFILL    = 3'd3,
		FILL      = 3'd4
	} ctrl_state_e;

endpackage

//--- dcache_sram.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_sram #(
	parameter int WIDTH = `TAG_ENTRY_BITS,
	parameter int DEPTH = `DCACHE_LINES
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  dcache_pkg::index_t addr_i,
	input  logic               we_i,
	input  logic [WIDTH-1:0]   wdata_i,
	output logic [WIDTH-1:0]   rdata_o
);

	// one row per cache line
	logic [WIDTH-1:0] mem [DEPTH];

	// read is combinational at the index
	assign rdata_o = mem[addr_i];

	// all zero after reset leaves every tag entry invalid
	always_ff @(posedge clk_i or negedge rst_i) begin
		if (!rst_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
	input  logic                 clk_i,
	input  logic                 rst_i,

	// processor side
	input  dcache_pkg::cpu_req_t cpu_req_i,
	output dcache_pkg::word_t    rdata_o,
	output logic                 stall_o,

	// memory side
	output dcache_pkg::mem_req_t mem_req_o,
	input  logic                 mem_ack_i,
	input  dcache_pkg::line_t    mem_rdata_i
);

	import dcache_pkg::*;

	// shared array index
	index_t     sram_index;

	// tag array
	logic       tag_we;
	tag_entry_t tag_wdata;
	tag_entry_t tag_rdata;

	// data array
	logic       data_we;
	line_t      data_wdata;
	line_t      data_rdata;

	dcache_ctrl u_ctrl (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cpu_req_i    (cpu_req_i),
		.rdata_o      (rdata_o),
		.stall_o      (stall_o),
		.mem_req_o    (mem_req_o),
		.mem_ack_i    (mem_ack_i),
		.mem_rdata_i  (mem_rdata_i),
		.sram_index_o (sram_index),
		.tag_we_o     (tag_we),
		.tag_wdata_o  (tag_wdata),
		.tag_rdata_i  (tag_rdata),
		.data_we_o    (data_we),
		.data_wdata_o (data_wdata),
		.data_rdata_i (data_rdata)
	);

	// valid, dirty and tag per line
	dcache_sram #(
		.WIDTH (`TAG_ENTRY_BITS),
		.DEPTH (`DCACHE_LINES)
	) u_tag_sram (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.addr_i  (sram_index),
		.we_i    (tag_we),
		.wdata_i (tag_wdata),
		.rdata_o (tag_rdata)
	);

	// line payload
	dcache_sram #(
		.WIDTH (`LINE_BITS),
		.DEPTH (`DCACHE_LINES)
	) u_data_sram (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.addr_i  (sram_index),
		.we_i    (data_we),
		.wdata_i (data_wdata),
		.rdata_o (data_rdata)
	);

endmodule

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_dcache \
	-f vlog.f

./obj_dir/Vtb_dcache > sim.log
cat sim.log

if grep -q "^Everything OK$" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever begin
			#10 clk_o = ~clk_o;
		end
	end

	// reset held low over the first three cycles
	initial begin
		rst_o = 1'b0;
		repeat (3) @(posedge clk_o);
		#1;
		rst_o = 1'b1;
	end

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache;

	import dcache_pkg::*;

	localparam int WORDS    = `LINE_BITS / `WORD_BITS;
	localparam int MAX_WAIT = 50;

	logic     clk;
	logic     rst;
	cpu_req_t cpu_req;
	word_t    rdata;
	logic     stall;
	mem_req_t mem_req;
	logic     mem_ack;
	line_t    mem_rdata;

	// memory request log
	int       wr_count;
	int       rd_count;
	int       wr_seq;
	int       rd_seq;
	addr_t    wr_addr;
	addr_t    rd_addr;
	line_t    wr_line;

	int       errors;
	int       timeouts;
	word_t    golden [addr_t];

	// result of the last access
	word_t    got;
	int       stalls;

	tb_clk_gen u_clk (
		.clk_o (clk),
		.rst_o (rst)
	);

	dcache_top DUT (
		.clk_i       (clk),
		.rst_i       (rst),
		.cpu_req_i   (cpu_req),
		.rdata_o     (rdata),
		.stall_o     (stall),
		.mem_req_o   (mem_req),
		.mem_ack_i   (mem_ack),
		.mem_rdata_i (mem_rdata)
	);

	tb_mem_model u_mem (
		.clk_i          (clk),
		.rst_i          (rst),
		.mem_req_i      (mem_req),
		.mem_ack_o      (mem_ack),
		.mem_rdata_o    (mem_rdata),
		.wr_count_o     (wr_count),
		.rd_count_o     (rd_count),
		.last_wr_seq_o  (wr_seq),
		.last_rd_seq_o  (rd_seq),
		.last_wr_addr_o (wr_addr),
		.last_wr_line_o (wr_line),
		.last_rd_addr_o (rd_addr)
	);

	// memory starts with each word equal to its byte address
	function automatic word_t golden_word(input addr_t a);
		if (golden.exists(a)) begin
			return golden[a];
		end
		return a;
	endfunction

	function automatic line_t golden_line(input addr_t line_addr);
		line_t l;
		for (int w = 0; w < WORDS; w++) begin
			l[w*`WORD_BITS +: `WORD_BITS] = golden_word(line_addr + 32'(w * 4));
		end
		return l;
	endfunction

	task automatic report(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic check(input string name, input line_t actual, input line_t expected);
		assert (actual === expected) else begin
			errors++;
			$display("Fail %s: got %0h, expected %0h", name, actual, expected);
		end
	endtask

	// request held until stall_o falls and dropped after the completing edge
	task automatic access(input logic wr, input addr_t addr, input word_t wdata);
		int n;
		n = 0;
		cpu_req = '{rd: !wr, wr: wr, addr: addr, wdata: wdata};
		@(negedge clk);
		while (stall && n < MAX_WAIT) begin
			n++;
			@(negedge clk);
		end
		stalls = n;
		got = rdata;
		if (stall) begin
			timeouts++;
			report("timeout: stall_o stayed high too long");
		end else if (wr) begin
			golden[addr] = wdata;
		end
		@(posedge clk);
		#1;
		cpu_req = '0;
	endtask

	task automatic read_check(input addr_t a);
		access(1'b0, a, '0);
		check("rdata_o", 256'(got), 256'(golden_word(a)));
	endtask

	initial begin
		int    n;
		int    wr_before;
		int    rd_before;
		addr_t a;
		addr_t b;
		void'($urandom(32'h5960_ebff));
		errors = 0;
		timeouts = 0;
		cpu_req = '0;
		n = 0;
		while (rst !== 1'b1 && n < 20) begin
			n++;
			@(posedge clk);
		end
		if (rst !== 1'b1) begin
			report("reset was never released");
		end
		@(posedge clk);
		#1;

		// idle after reset
		@(negedge clk);
		check("stall_o", 256'(stall), '0);
		check("mem_req_o.enable", 256'(mem_req.enable), '0);
		check("mem_req_o.write", 256'(mem_req.write), '0);
		@(posedge clk);
		#1;

		// read miss and then a hit in the same line
		a = 32'h0000_0124;
		wr_before = wr_count;
		rd_before = rd_count;
		read_check(a);
		assert (stalls > 0) else report("read miss did not raise stall_o");
		check("memory reads", 256'(rd_count), 256'(rd_before + 1));
		check("memory writes", 256'(wr_count), 256'(wr_before));
		check("mem_req_o.addr", 256'(rd_addr), 256'(a & ~32'h1f));
		read_check(a + 32'h8);
		assert (stalls == 0) else report("read hit stalled");
		check("memory reads", 256'(rd_count), 256'(rd_before + 1));

		// write hit and a read back of the whole line
		access(1'b1, a + 32'h4, 32'hc0de_1234);
		assert (stalls == 0) else report("write hit stalled");
		for (int w = 0; w < WORDS; w++) begin
			read_check((a & ~32'h1f) + 32'(w * 4));
			assert (stalls == 0) else report("read of a resident line stalled");
		end
		check("memory reads", 256'(rd_count), 256'(rd_before + 1));
		check("memory writes", 256'(wr_count), 256'(wr_before));

		// dirty victim at the same index under another tag
		b = a + 32'h400;
		read_check(b);
		check("memory writes", 256'(wr_count), 256'(wr_before + 1));
		check("memory reads", 256'(rd_count), 256'(rd_before + 2));
		check("mem_req_o.addr", 256'(wr_addr), 256'(a & ~32'h1f));
		check("mem_req_o.data", wr_line, golden_line(a & ~32'h1f));
		check("mem_req_o.addr", 256'(rd_addr), 256'(b & ~32'h1f));
		assert (wr_seq < rd_seq) else report("refill read came before the write-back");

		// clean victim needs only a refill
		read_check(a + 32'h800);
		check("memory writes", 256'(wr_count), 256'(wr_before + 1));
		check("memory reads", 256'(rd_count), 256'(rd_before + 3));

		// random mix over four tags and four indices
		for (int i = 0; i < 200; i++) begin
			a = (($urandom % 4) << 10) | (($urandom % 4) << 5) | (($urandom % 8) << 2);
			wr_before = wr_count;
			if ($urandom % 2 == 1) begin
				access(1'b1, a, $urandom);
			end else begin
				read_check(a);
			end
			if (wr_count != wr_before) begin
				check("memory writes", 256'(wr_count), 256'(wr_before + 1));
				check("mem_req_o.data", wr_line, golden_line(wr_addr));
			end
		end

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_mem_model (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  dcache_pkg::mem_req_t mem_req_i,
	output logic                 mem_ack_o,
	output dcache_pkg::line_t    mem_rdata_o,
	output int                   wr_count_o,
	output int                   rd_count_o,
	output int                   last_wr_seq_o,
	output int                   last_rd_seq_o,
	output dcache_pkg::addr_t    last_wr_addr_o,
	output dcache_pkg::line_t    last_wr_line_o,
	output dcache_pkg::addr_t    last_rd_addr_o
);

	import dcache_pkg::*;

	// only lines that were written are stored
	line_t lines [addr_t];
	logic  busy;
	int    wait_cycles;
	int    seq;

	// untouched lines hold their own byte addresses
	function automatic line_t stored_line(input addr_t line_addr);
		line_t l;
		if (lines.exists(line_addr)) begin
			l = lines[line_addr];
		end else begin
			for (int w = 0; w < `LINE_BITS / `WORD_BITS; w++) begin
				l[w*`WORD_BITS +: `WORD_BITS] = line_addr + 32'(w * 4);
			end
		end
		return l;
	endfunction

	always @(posedge clk_i or negedge rst_i) begin
		if (!rst_i) begin
			busy           <= 1'b0;
			wait_cycles    <= 0;
			seq            <= 0;
			mem_ack_o      <= 1'b0;
			mem_rdata_o    <= '0;
			wr_count_o     <= 0;
			rd_count_o     <= 0;
			last_wr_seq_o  <= 0;
			last_rd_seq_o  <= 0;
			last_wr_addr_o <= '0;
			last_wr_line_o <= '0;
			last_rd_addr_o <= '0;
		end else if (mem_ack_o) begin
			// request ends with the acknowledge cycle
			mem_ack_o <= 1'b0;
			busy      <= 1'b0;
		end else if (busy) begin
			if (wait_cycles > 1) begin
				wait_cycles <= wait_cycles - 1;
			end else begin
				mem_ack_o <= 1'b1;
				seq       <= seq + 1;
				if (mem_req_i.write) begin
					lines[mem_req_i.addr] = mem_req_i.data;
					wr_count_o     <= wr_count_o + 1;
					last_wr_seq_o  <= seq + 1;
					last_wr_addr_o <= mem_req_i.addr;
					last_wr_line_o <= mem_req_i.data;
				end else begin
					mem_rdata_o    <= stored_line(mem_req_i.addr);
					rd_count_o     <= rd_count_o + 1;
					last_rd_seq_o  <= seq + 1;
					last_rd_addr_o <= mem_req_i.addr;
				end
			end
		end else if (mem_req_i.enable) begin
			busy        <= 1'b1;
			wait_cycles <= $urandom_range(1, 4);
		end
	end

endmodule

//--- vlog.f
+incdir+.
dcache_pkg.sv
dcache_sram.sv
dcache_ctrl.sv
dcache_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_dcache.sv
